// File: src/mpu_pkg.sv
// Shared types and constants for the data-side memory protection unit.
// Imported by the lookup, the fault state machine and the top level.

package mpu_pkg;

  // Upper limit on the number of configured PMA regions
  localparam int PMA_MAX_REGIONS = 16;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  //////////////////////////////
  // PMA region description
  //////////////////////////////

  // Bounds are word addresses, high bound is exclusive
  typedef struct packed {
    logic [29:0] word_addr_low;
    logic [29:0] word_addr_high;
    logic        main;
    logic        bufferable;
    logic        cacheable;
  } pma_cfg_t;

  // Regions exist but none of them matched
  localparam pma_cfg_t PMA_R_DEFAULT = '{
    word_addr_low:  30'h0,
    word_addr_high: 30'h0,
    main:           1'b0,
    bufferable:     1'b0,
    cacheable:      1'b0
  };

  // No regions configured, everything is main memory
  localparam pma_cfg_t NO_PMA_R_DEFAULT = '{
    word_addr_low:  30'h0,
    word_addr_high: 30'h0,
    main:           1'b1,
    bufferable:     1'b0,
    cacheable:      1'b0
  };

  //////////////////////////////
  // Request and response words
  //////////////////////////////

  typedef struct packed {
    addr_t addr;
    data_t wdata;
    logic  we;
    logic  instr_fetch;
    logic  misaligned;
  } core_req_t;

  typedef struct packed {
    addr_t addr;
    data_t wdata;
    logic  we;
    logic  bufferable;
    logic  cacheable;
  } bus_req_t;

  typedef struct packed {
    data_t rdata;
    logic  bus_err;
  } bus_resp_t;

  typedef enum logic [1:0] {
    MPU_OK       = 2'b00,
    MPU_RE_FAULT = 2'b01,
    MPU_WR_FAULT = 2'b10
  } mpu_status_e;

  typedef struct packed {
    data_t       rdata;
    logic        bus_err;
    mpu_status_e mpu_status;
  } core_resp_t;

  // Fault response FSM states
  typedef enum logic [1:0] {
    MPU_IDLE        = 2'b00,
    MPU_WAIT_BUS    = 2'b01,
    MPU_RE_ERR_RESP = 2'b10,
    MPU_WR_ERR_RESP = 2'b11
  } mpu_state_e;

endpackage

// File: src/pma_lookup.sv
// Combinational PMA region lookup for one data access.
// Picks the lowest-numbered matching region and derives the bus
// attributes and the PMA fault flag from it.

module pma_lookup import mpu_pkg::*; #(
  parameter int       PMA_NUM_REGIONS = 0,
  parameter pma_cfg_t PMA_CFG [PMA_MAX_REGIONS] = '{PMA_MAX_REGIONS{PMA_R_DEFAULT}}
) (
  input  addr_t    addr_i,
  input  logic     instr_fetch_i,
  input  logic     misaligned_i,
  input  logic     we_i,
  output pma_cfg_t cfg_o,
  output logic     bufferable_o,
  output logic     pma_err_o
);

  localparam int IDX_W = $clog2(PMA_MAX_REGIONS);

  logic [29:0]                word_addr;
  logic [PMA_MAX_REGIONS-1:0] region_hit;
  logic                       match_found;
  logic [IDX_W-1:0]           match_idx;
  pma_cfg_t                   sel_cfg;

  // Byte offset bits take no part in matching
  assign word_addr = addr_i[31:2];

  //////////////////////////////
  // Per-region address compare
  //////////////////////////////

  for (genvar g = 0; g < PMA_MAX_REGIONS; g++) begin : gen_region
    if (g < PMA_NUM_REGIONS) begin : gen_used
      // Low bound inclusive, high bound exclusive
      assign region_hit[g] = (word_addr >= PMA_CFG[g].word_addr_low) &&
                             (word_addr <  PMA_CFG[g].word_addr_high);
    end else begin : gen_unused
      assign region_hit[g] = 1'b0;
    end
  end

  //////////////////////////////
  // Lowest-index priority pick
  //////////////////////////////

  always_comb begin
    match_found = 1'b0;
    match_idx   = '0;
    for (int i = 0; i < PMA_MAX_REGIONS; i++) begin
      if (region_hit[i] && !match_found) begin
        match_found = 1'b1;
        match_idx   = IDX_W'(i);
      end
    end
  end

  // Attribute selection with the two default cases
  always_comb begin
    if (PMA_NUM_REGIONS == 0) begin
      sel_cfg = NO_PMA_R_DEFAULT;
    end else if (match_found) begin
      sel_cfg = PMA_CFG[match_idx];
    end else begin
      sel_cfg = PMA_R_DEFAULT;
    end
  end

  assign cfg_o = sel_cfg;

  // Loads are never posted, only stores may be bufferable
  assign bufferable_o = we_i && sel_cfg.bufferable;

  // Fetches and misaligned accesses are only legal in main memory
  assign pma_err_o = (instr_fetch_i || misaligned_i) && !sel_cfg.main;

endmodule

// File: src/mpu_err_fsm.sv
// Fault response sequencer for the protection unit.
// Tracks outstanding bus transactions and, after a faulting request,
// waits for them to drain before issuing the error response.

module mpu_err_fsm import mpu_pkg::*; #(
  parameter int MAX_OUTSTANDING = 4
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        fault_accept_i,
  input  logic        fault_we_i,
  input  logic        bus_req_xfer_i,
  input  logic        bus_resp_xfer_i,
  input  logic        core_resp_ready_i,
  output logic        block_core_o,
  output logic        block_bus_o,
  output logic        err_resp_valid_o,
  output mpu_status_e err_status_o
);

  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;
  mpu_state_e       state_q;
  mpu_state_e       state_d;
  logic             err_we_q;

  // Error response state for the given access direction
  function automatic mpu_state_e err_state(input logic we);
    return we ? MPU_WR_ERR_RESP : MPU_RE_ERR_RESP;
  endfunction

  //////////////////////////////
  // Outstanding transaction count
  //////////////////////////////

  always_comb begin
    cnt_d = cnt_q;
    case ({bus_req_xfer_i, bus_resp_xfer_i})
      2'b10: cnt_d = cnt_q + CNT_W'(1);
      2'b01: cnt_d = cnt_q - CNT_W'(1);
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  //////////////////////////////
  // Fault response FSM
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      MPU_IDLE: begin
        if (fault_accept_i) begin
          // Earlier bus traffic has to come back first
          if (cnt_q != '0) begin
            state_d = MPU_WAIT_BUS;
          end else begin
            state_d = err_state(fault_we_i);
          end
        end
      end
      MPU_WAIT_BUS: begin
        if (cnt_q == '0) begin
          state_d = err_state(err_we_q);
        end
      end
      MPU_RE_ERR_RESP,
      MPU_WR_ERR_RESP: begin
        // Hold the response until the core takes it
        if (core_resp_ready_i) begin
          state_d = MPU_IDLE;
        end
      end
      default: state_d = MPU_IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= MPU_IDLE;
      err_we_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (fault_accept_i && (state_q == MPU_IDLE)) begin
        err_we_q <= fault_we_i;
      end
    end
  end

  // Both sides stay blocked until the fault is answered
  assign block_core_o = (state_q != MPU_IDLE);
  assign block_bus_o  = (state_q != MPU_IDLE);

  assign err_resp_valid_o = (state_q == MPU_RE_ERR_RESP) ||
                            (state_q == MPU_WR_ERR_RESP);

  always_comb begin
    case (state_q)
      MPU_RE_ERR_RESP: err_status_o = MPU_RE_FAULT;
      MPU_WR_ERR_RESP: err_status_o = MPU_WR_FAULT;
      default:         err_status_o = MPU_OK;
    endcase
  end

endmodule

// File: src/mpu_top.sv
// Data-side memory protection unit between the core load/store port
// and the memory bus. Passing requests go straight to the bus, faults
// are answered locally once earlier bus traffic has returned.

module mpu_top import mpu_pkg::*; #(
  parameter int       PMA_NUM_REGIONS = 0,
  parameter pma_cfg_t PMA_CFG [PMA_MAX_REGIONS] = '{PMA_MAX_REGIONS{PMA_R_DEFAULT}},
  parameter int       MAX_OUTSTANDING = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  // Core request
  input  logic       core_req_valid_i,
  input  core_req_t  core_req_i,
  output logic       core_req_ready_o,
  // Bus request
  output logic       bus_req_valid_o,
  output bus_req_t   bus_req_o,
  input  logic       bus_req_ready_i,
  // Bus response
  input  logic       bus_resp_valid_i,
  input  bus_resp_t  bus_resp_i,
  output logic       bus_resp_ready_o,
  // Core response
  output logic       core_resp_valid_o,
  output core_resp_t core_resp_o,
  input  logic       core_resp_ready_i
);

  pma_cfg_t    pma_cfg;
  logic        pma_bufferable;
  logic        pma_err;
  logic        block_core;
  logic        block_bus;
  logic        err_resp_valid;
  mpu_status_e err_status;
  logic        fault_accept;
  logic        bus_req_xfer;
  logic        bus_resp_xfer;

  pma_lookup #(
    .PMA_NUM_REGIONS (PMA_NUM_REGIONS),
    .PMA_CFG         (PMA_CFG)
  ) pma_lookup_i (
    .addr_i        (core_req_i.addr),
    .instr_fetch_i (core_req_i.instr_fetch),
    .misaligned_i  (core_req_i.misaligned),
    .we_i          (core_req_i.we),
    .cfg_o         (pma_cfg),
    .bufferable_o  (pma_bufferable),
    .pma_err_o     (pma_err)
  );

  //////////////////////////////
  // Request side
  //////////////////////////////

  // Faults are taken whenever idle, passing requests wait on the bus
  assign core_req_ready_o = !block_core && (pma_err || bus_req_ready_i);
  assign bus_req_valid_o  = core_req_valid_i && !pma_err && !block_bus;

  assign bus_req_o.addr       = core_req_i.addr;
  assign bus_req_o.wdata      = core_req_i.wdata;
  assign bus_req_o.we         = core_req_i.we;
  assign bus_req_o.bufferable = pma_bufferable;
  assign bus_req_o.cacheable  = pma_cfg.cacheable;

  assign fault_accept = core_req_valid_i && core_req_ready_o && pma_err;
  assign bus_req_xfer = bus_req_valid_o && bus_req_ready_i;

  //////////////////////////////
  // Response side
  //////////////////////////////

  assign bus_resp_ready_o = core_resp_ready_i;
  assign bus_resp_xfer    = bus_resp_valid_i && bus_resp_ready_o;

  // Error responses only start once the bus is drained
  assign core_resp_valid_o = bus_resp_valid_i || err_resp_valid;

  always_comb begin
    if (err_resp_valid) begin
      core_resp_o.rdata      = '0;
      core_resp_o.bus_err    = 1'b0;
      core_resp_o.mpu_status = err_status;
    end else begin
      core_resp_o.rdata      = bus_resp_i.rdata;
      core_resp_o.bus_err    = bus_resp_i.bus_err;
      core_resp_o.mpu_status = MPU_OK;
    end
  end

  mpu_err_fsm #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) mpu_err_fsm_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .fault_accept_i    (fault_accept),
    .fault_we_i        (core_req_i.we),
    .bus_req_xfer_i    (bus_req_xfer),
    .bus_resp_xfer_i   (bus_resp_xfer),
    .core_resp_ready_i (core_resp_ready_i),
    .block_core_o      (block_core),
    .block_bus_o       (block_bus),
    .err_resp_valid_o  (err_resp_valid),
    .err_status_o      (err_status)
  );

endmodule

// File: test/mpu_tb.sv
// Testbench for the data-side protection unit.
// Random core traffic against three PMA regions and a gap, an in-order bus
// responder model and a checker that compares with a reference function.

module mpu_tb import mpu_pkg::*; ();

  localparam int NUM_REGIONS     = 3;
  localparam int MAX_OUTSTANDING = 4;
  localparam int NUM_REQS        = 400;
  localparam int RESET_CYCLES    = 8;
  localparam int WATCHDOG_CYCLES = NUM_REQS * 40;

  // Bounds are word addresses with the byte range noted above each region
  // Byte range 0x1000 to 0x2000
  localparam pma_cfg_t REGION0 = '{word_addr_low: 30'h400, word_addr_high: 30'h800,
                                   main: 1'b1, bufferable: 1'b1, cacheable: 1'b1};
  // Byte range 0x1000 to 0x3000 overlapping region 0
  localparam pma_cfg_t REGION1 = '{word_addr_low: 30'h400, word_addr_high: 30'hC00,
                                   main: 1'b1, bufferable: 1'b0, cacheable: 1'b1};
  // Byte range 0x4000 to 0x5000 with the gap at 0x3000 left unmatched
  localparam pma_cfg_t REGION2 = '{word_addr_low: 30'h1000, word_addr_high: 30'h1400,
                                   main: 1'b0, bufferable: 1'b1, cacheable: 1'b0};
  localparam pma_cfg_t REGION_CFG [PMA_MAX_REGIONS] =
    '{0: REGION0, 1: REGION1, 2: REGION2, default: PMA_R_DEFAULT};

  typedef struct packed {
    logic       fault;
    bus_req_t   bus_req;
    core_resp_t resp;
  } expect_t;

  logic       clk;
  logic       rst_n;
  logic       core_req_valid_i;
  core_req_t  core_req_i;
  logic       core_req_ready_o;
  logic       bus_req_valid_o;
  bus_req_t   bus_req_o;
  logic       bus_req_ready_i;
  logic       bus_resp_valid_i;
  bus_resp_t  bus_resp_i;
  logic       bus_resp_ready_o;
  logic       core_resp_valid_o;
  core_resp_t core_resp_o;
  logic       core_resp_ready_i;

  logic [31:0] lfsr_q;
  addr_t       bus_pend_q [$];
  expect_t     exp_q [$];
  int          err_count;
  int          check_count;
  int          resp_count;
  logic        last_valid;
  logic        last_ready;
  core_resp_t  last_resp;

  mpu_top #(
    .PMA_NUM_REGIONS (NUM_REGIONS),
    .PMA_CFG         (REGION_CFG),
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) mpu_top_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .core_req_valid_i  (core_req_valid_i),
    .core_req_i        (core_req_i),
    .core_req_ready_o  (core_req_ready_o),
    .bus_req_valid_o   (bus_req_valid_o),
    .bus_req_o         (bus_req_o),
    .bus_req_ready_i   (bus_req_ready_i),
    .bus_resp_valid_i  (bus_resp_valid_i),
    .bus_resp_i        (bus_resp_i),
    .bus_resp_ready_o  (bus_resp_ready_o),
    .core_resp_valid_o (core_resp_valid_o),
    .core_resp_o       (core_resp_o),
    .core_resp_ready_i (core_resp_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////
  // Random source
  //////////////////////////////

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Address biased into region 0, region 1 only, region 2 and the gap
  task automatic make_request(output core_req_t req);
    logic [31:0] sel;
    logic [31:0] offs;
    logic [31:0] bit_we;
    addr_t       base;
    sel  = rand_bits(2);
    offs = rand_bits(10);
    case (sel[1:0])
      2'd0:    base = 32'h0000_1000;
      2'd1:    base = 32'h0000_2000;
      2'd2:    base = 32'h0000_4000;
      default: base = 32'h0000_3000;
    endcase
    req.wdata       = rand_bits(32);
    req.instr_fetch = (rand_bits(3) == 32'd0);
    bit_we          = rand_bits(1);
    req.we          = !req.instr_fetch && bit_we[0];
    req.misaligned  = (rand_bits(3) == 32'd0);
    req.addr        = base | {20'h0, offs[9:0], 1'b0, req.misaligned};
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic expect_t expected_access(input core_req_t req);
    expect_t  e;
    pma_cfg_t region;
    logic     hit;
    region = PMA_R_DEFAULT;
    hit    = 1'b0;
    // Lowest index wins
    for (int i = 0; i < NUM_REGIONS; i++) begin
      if (!hit && (req.addr[31:2] >= REGION_CFG[i].word_addr_low) &&
          (req.addr[31:2] < REGION_CFG[i].word_addr_high)) begin
        region = REGION_CFG[i];
        hit    = 1'b1;
      end
    end
    e.fault              = (req.instr_fetch || req.misaligned) && !region.main;
    e.bus_req.addr       = req.addr;
    e.bus_req.wdata      = req.wdata;
    e.bus_req.we         = req.we;
    e.bus_req.bufferable = req.we && region.bufferable;
    e.bus_req.cacheable  = region.cacheable;
    if (e.fault) begin
      e.resp.rdata      = '0;
      e.resp.bus_err    = 1'b0;
      e.resp.mpu_status = req.we ? MPU_WR_FAULT : MPU_RE_FAULT;
    end else begin
      // Responder returns the inverted address and flags an error on address bit 4
      e.resp.rdata      = ~req.addr;
      e.resp.bus_err    = req.addr[4];
      e.resp.mpu_status = MPU_OK;
    end
    return e;
  endfunction

  //////////////////////////////
  // Stimulus and bus responder
  //////////////////////////////

  initial begin : drive_inputs
    core_req_t req;
    addr_t     breq_addr;
    logic      req_fire;
    logic      breq_fire;
    logic      bresp_fire;
    int        sent;
    lfsr_q            = 32'hcc09be86;
    sent              = 0;
    rst_n             = 1'b0;
    core_req_valid_i  = 1'b0;
    core_req_i        = '0;
    bus_req_ready_i   = 1'b0;
    bus_resp_valid_i  = 1'b0;
    bus_resp_i        = '0;
    core_resp_ready_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
    forever begin
      // Handshakes are decided by the values stable before the edge
      @(negedge clk);
      req_fire   = core_req_valid_i && core_req_ready_o;
      breq_fire  = bus_req_valid_o && bus_req_ready_i;
      bresp_fire = bus_resp_valid_i && bus_resp_ready_o;
      breq_addr  = bus_req_o.addr;
      @(posedge clk);
      #1;
      if (breq_fire) begin
        bus_pend_q.push_back(breq_addr);
      end
      if (bresp_fire) begin
        bus_pend_q.delete(0);
        bus_resp_valid_i = 1'b0;
      end
      // Next in-order response after a random delay
      if (!bus_resp_valid_i && (bus_pend_q.size() > 0) && (rand_bits(1) == 32'd1)) begin
        bus_resp_valid_i   = 1'b1;
        bus_resp_i.rdata   = ~bus_pend_q[0];
        bus_resp_i.bus_err = bus_pend_q[0][4];
      end
      if (req_fire) begin
        core_req_valid_i = 1'b0;
      end
      if (!core_req_valid_i && (sent < NUM_REQS) && (rand_bits(2) != 32'd0)) begin
        make_request(req);
        core_req_i       = req;
        core_req_valid_i = 1'b1;
        sent++;
      end
      bus_req_ready_i   = (bus_pend_q.size() < MAX_OUTSTANDING) && (rand_bits(2) != 32'd0);
      core_resp_ready_i = (rand_bits(2) != 32'd0);
    end
  end

  //////////////////////////////
  // Checker
  //////////////////////////////

  initial begin : compare_outputs
    expect_t want;
    expect_t head;
    err_count   = 0;
    check_count = 0;
    resp_count  = 0;
    last_valid  = 1'b0;
    last_ready  = 1'b0;
    last_resp   = '0;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      // Bus response ready follows the core side
      check_count++;
      if (bus_resp_ready_o !== core_resp_ready_i) begin
        err_count++;
        $display("CHECK FAILED bus_resp_ready expected %b actual %b",
                 core_resp_ready_i, bus_resp_ready_o);
      end
      // Stalled response must not move
      if (last_valid && !last_ready) begin
        check_count++;
        if (!core_resp_valid_o || (core_resp_o != last_resp)) begin
          err_count++;
          $display("CHECK FAILED resp_hold expected %h actual %h valid %b",
                   last_resp, core_resp_o, core_resp_valid_o);
        end
      end
      if (core_resp_valid_o && core_resp_ready_i) begin
        resp_count++;
        if (exp_q.size() == 0) begin
          err_count++;
          $display("Core response at time %0t with no request outstanding", $time);
        end else begin
          head = exp_q.pop_front();
          check_count++;
          if (core_resp_o != head.resp) begin
            err_count++;
            $display("CHECK FAILED core_resp expected %h actual %h", head.resp, core_resp_o);
          end
        end
      end
      if (core_req_valid_i && core_req_ready_o) begin
        want = expected_access(core_req_i);
        check_count++;
        if (want.fault) begin
          if (bus_req_valid_o) begin
            err_count++;
            $display("CHECK FAILED fault_no_bus expected 0 actual %b", bus_req_valid_o);
          end
        end else if (!(bus_req_valid_o && bus_req_ready_i)) begin
          err_count++;
          $display("Passing request at %h accepted without a bus transfer", core_req_i.addr);
        end else if (bus_req_o != want.bus_req) begin
          err_count++;
          $display("CHECK FAILED bus_req expected %h actual %h", want.bus_req, bus_req_o);
        end
        exp_q.push_back(want);
      end else if (bus_req_valid_o && bus_req_ready_i) begin
        err_count++;
        $display("Bus request at %h sent without an accepted core request", bus_req_o.addr);
      end
      last_valid = core_resp_valid_o;
      last_ready = core_resp_ready_i;
      last_resp  = core_resp_o;
    end
  end

  initial begin : finish_run
    wait (rst_n === 1'b1);
    wait (resp_count == NUM_REQS);
    repeat (4) @(posedge clk);
    if (exp_q.size() != 0) begin
      err_count++;
      $display("%0d expected responses never arrived", exp_q.size());
    end
    $display("checks %0d, errors %0d, responses %0d", check_count, err_count, resp_count);
    if (err_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clk);
    $display("Run did not complete, %0d of %0d responses seen, errors %0d",
             resp_count, NUM_REQS, err_count);
    $display("test failed");
    $finish;
  end

endmodule

// File: vlog.f
src/mpu_pkg.sv
src/pma_lookup.sv
src/mpu_err_fsm.sv
src/mpu_top.sv
test/mpu_tb.sv

// File: run_sim.sh
#!/bin/sh
rm -f sim.log &&
verilator --binary --timing --top-module mpu_tb -f vlog.f -o mpu_sim &&
./obj_dir/mpu_sim | tee sim.log
grep -qx "test passed" sim.log && echo "simulation passed" && exit 0 ||
echo "simulation failed" && exit 1
